/* fp_pkg.sv */
// Single-precision format constants, field types and rounding shared by every converter stage
`default_nettype none

package fp_pkg;

  // ==================================================
  // Format constants
  // ==================================================
  localparam int EXP_BITS         = 8;
  localparam int FRAC_BITS        = 23;
  localparam int MANT_BITS        = 24;
  localparam int EXP_BIAS         = 127;
  localparam int INT_BITS         = 32;
  localparam int EXP_EXT_BITS     = 10;
  localparam int MAX_EXP_SIGNED   = 30;
  localparam int MAX_EXP_UNSIGNED = 31;

  typedef logic [INT_BITS-1:0]                fp_word_t;
  typedef logic [INT_BITS-1:0]                int_word_t;
  typedef logic [EXP_BITS-1:0]                exp_t;
  typedef logic [FRAC_BITS-1:0]               frac_t;
  typedef logic [MANT_BITS-1:0]               mant_t;
  typedef logic signed [EXP_EXT_BITS-1:0]     uexp_t;
  typedef logic [$clog2(INT_BITS)-1:0]        lzc_t;

  // Saturation values for out-of-range conversions
  localparam int_word_t INT_MAX  = 32'h7FFF_FFFF;
  localparam int_word_t INT_MIN  = 32'h8000_0000;
  localparam int_word_t UINT_MAX = 32'hFFFF_FFFF;

  typedef struct packed {
    logic nv;
    logic nx;
  } fp_flags_t;

  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } round_mode_e;

  // Codes above RMM fall through to round to nearest even
  function automatic logic round_up(input round_mode_e rm, input logic sign, input logic lsb,
                                    input logic rnd, input logic sticky);
    logic inc;
    case (rm)
      RM_RTZ:  inc = 1'b0;
      RM_RDN:  inc = sign & (rnd | sticky);
      RM_RUP:  inc = ~sign & (rnd | sticky);
      RM_RMM:  inc = rnd;
      default: inc = rnd & (sticky | lsb);
    endcase
    return inc;
  endfunction

endpackage

`default_nettype wire

/* cvt_pkg.sv */
// Converter opcodes, sequencer states and stage structs; codes 6 and 7 of the opcode are unused
`default_nettype none

package cvt_pkg;

  typedef enum logic [2:0] {
    OP_FCVT_W_S  = 3'd0,
    OP_FCVT_WU_S = 3'd1,
    OP_FCVT_S_W  = 3'd2,
    OP_FCVT_S_WU = 3'd3,
    OP_FMV_X_W   = 3'd4,
    OP_FMV_W_X   = 3'd5
  } cvt_op_e;

  typedef enum logic [2:0] {
    ST_IDLE = 3'd0,
    ST_S1   = 3'd1,
    ST_S2   = 3'd2,
    ST_S3   = 3'd3,
    ST_S4   = 3'd4
  } cvt_state_e;

  // ==================================================
  // Stage boundary structs
  // ==================================================

  // Stage 1 to stage 2, both conversion directions
  typedef struct packed {
    logic              fp_sign;
    logic              fp_is_zero;
    logic              fp_is_inf;
    logic              fp_is_nan;
    fp_pkg::mant_t     mant;
    fp_pkg::uexp_t     uexp;
    fp_pkg::int_word_t int_mag;
    logic              int_sign;
    logic              int_is_zero;
    fp_pkg::lzc_t      lzc;
  } unpack_t;

  // Stage 2 to stage 3, float to integer only
  typedef struct packed {
    fp_pkg::int_word_t value;
    logic              rnd;
    logic              sticky;
    logic              inexact_pre;
    logic              forced;
    fp_pkg::int_word_t forced_value;
    logic              forced_nv;
    logic              sign;
    logic              is_unsigned;
  } f2i_pre_t;

  typedef struct packed {
    fp_pkg::fp_word_t fp;
    logic             nx;
  } i2f_res_t;

endpackage

`default_nettype wire

/* fcvt_unpack.sv */
// Combinational stage 1; i_signed selects two's complement for the integer operand
`timescale 1ns/1ns
`default_nettype none

module fcvt_unpack (
  input  fp_pkg::fp_word_t  i_fp,
  input  fp_pkg::int_word_t i_int,
  input  logic              i_signed,
  output cvt_pkg::unpack_t  o_unp
);

  fp_pkg::exp_t      exp_field;
  fp_pkg::frac_t     frac_field;
  logic              exp_zero;
  logic              exp_ones;
  fp_pkg::int_word_t int_mag;
  fp_pkg::lzc_t      lzc;
  logic              lzc_found;

  assign exp_field  = i_fp[fp_pkg::FRAC_BITS +: fp_pkg::EXP_BITS];
  assign frac_field = i_fp[fp_pkg::FRAC_BITS-1:0];
  assign exp_zero   = (exp_field == '0);
  assign exp_ones   = (exp_field == '1);

  // Float classification and fields
  always_comb begin
    o_unp.fp_sign    = i_fp[fp_pkg::INT_BITS-1];
    o_unp.fp_is_zero = exp_zero && (frac_field == '0);
    o_unp.fp_is_inf  = exp_ones && (frac_field == '0);
    o_unp.fp_is_nan  = exp_ones && (frac_field != '0);
    o_unp.mant       = {~exp_zero, frac_field};
    // Subnormals share the exponent of the smallest normal
    if (exp_zero) begin
      o_unp.uexp = fp_pkg::uexp_t'(1 - fp_pkg::EXP_BIAS);
    end else begin
      o_unp.uexp = $signed({2'b00, exp_field}) - fp_pkg::uexp_t'(fp_pkg::EXP_BIAS);
    end
  end

  // Integer magnitude and leading zero count
  always_comb begin
    o_unp.int_sign = i_signed & i_int[fp_pkg::INT_BITS-1];
    int_mag        = o_unp.int_sign ? -i_int : i_int;
    lzc            = '0;
    lzc_found      = 1'b0;
    for (int i = fp_pkg::INT_BITS - 1; i >= 0; i--) begin
      if (!lzc_found) begin
        if (int_mag[i]) begin
          lzc_found = 1'b1;
        end else begin
          lzc = lzc + 1'b1;
        end
      end
    end
    o_unp.int_mag     = int_mag;
    o_unp.int_is_zero = (int_mag == '0);
    o_unp.lzc         = lzc;
    if (int_mag != '0) begin
      assert (int_mag[(fp_pkg::INT_BITS - 1) - lzc])
        else $error("lzc %0d does not point at the leading one of %h", lzc, int_mag);
    end
  end

endmodule

`default_nettype wire

/* fcvt_f2i_align.sv */
// Combinational stage 2 of float to integer; specials are decided here and rounding comes later
`timescale 1ns/1ns
`default_nettype none

module fcvt_f2i_align (
  input  cvt_pkg::unpack_t  i_unp,
  input  logic              i_unsigned,
  output cvt_pkg::f2i_pre_t o_pre
);

  fp_pkg::uexp_t                     uexp;
  fp_pkg::uexp_t                     exp_limit;
  logic [$clog2(2*fp_pkg::INT_BITS)-1:0] shift_amt;
  logic [2*fp_pkg::INT_BITS-1:0]     wide;
  fp_pkg::int_word_t                 sat_value;

  assign uexp = i_unp.uexp;

  // Negative inputs may reach 2^31 in magnitude, the range check in stage 4 sorts them out
  assign exp_limit = (i_unsigned || i_unp.fp_sign) ?
                     fp_pkg::uexp_t'(fp_pkg::MAX_EXP_UNSIGNED) :
                     fp_pkg::uexp_t'(fp_pkg::MAX_EXP_SIGNED);

  // Value returned on overflow or infinity
  always_comb begin
    if (i_unp.fp_sign) begin
      sat_value = i_unsigned ? '0 : fp_pkg::INT_MIN;
    end else begin
      sat_value = i_unsigned ? fp_pkg::UINT_MAX : fp_pkg::INT_MAX;
    end
  end

  always_comb begin
    o_pre             = '0;
    o_pre.sign        = i_unp.fp_sign;
    o_pre.is_unsigned = i_unsigned;
    shift_amt         = '0;
    wide              = '0;

    if (i_unp.fp_is_nan) begin
      o_pre.forced       = 1'b1;
      o_pre.forced_nv    = 1'b1;
      o_pre.forced_value = i_unsigned ? fp_pkg::UINT_MAX : fp_pkg::INT_MAX;
    end else if (i_unp.fp_is_inf || (uexp > exp_limit)) begin
      o_pre.forced       = 1'b1;
      o_pre.forced_nv    = 1'b1;
      o_pre.forced_value = sat_value;
    end else if (i_unp.fp_is_zero) begin
      o_pre.forced = 1'b1;
    end else if (uexp < 0) begin
      // Magnitude below one, only round and sticky survive
      o_pre.rnd         = (uexp == -1);
      o_pre.sticky      = (uexp == -1) ? |i_unp.mant[fp_pkg::FRAC_BITS-1:0] : 1'b1;
      o_pre.inexact_pre = 1'b1;
    end else begin
      // Wide word holds the value scaled by 2^32, the upper half is the integer part
      shift_amt = uexp[$bits(shift_amt)-1:0] +
                  $bits(shift_amt)'(fp_pkg::INT_BITS - fp_pkg::FRAC_BITS);
      wide      = {{fp_pkg::INT_BITS{1'b0}}, {(fp_pkg::INT_BITS - fp_pkg::MANT_BITS){1'b0}},
                   i_unp.mant} << shift_amt;
      o_pre.value       = wide[2*fp_pkg::INT_BITS-1:fp_pkg::INT_BITS];
      o_pre.rnd         = wide[fp_pkg::INT_BITS-1];
      o_pre.sticky      = |wide[fp_pkg::INT_BITS-2:0];
      o_pre.inexact_pre = o_pre.rnd | o_pre.sticky;
    end
  end

endmodule

`default_nettype wire

/* fcvt_i2f_norm.sv */
// Combinational stage 2 of integer to float; a zero integer always gives +0
`timescale 1ns/1ns
`default_nettype none

module fcvt_i2f_norm (
  input  cvt_pkg::unpack_t    i_unp,
  input  fp_pkg::round_mode_e i_rm,
  output cvt_pkg::i2f_res_t   o_res
);

  fp_pkg::int_word_t       norm;
  fp_pkg::exp_t            exp_val;
  fp_pkg::frac_t           frac;
  logic                    rnd;
  logic                    sticky;
  logic                    inc;
  logic [fp_pkg::FRAC_BITS:0] frac_sum;

  // Leading one lands on the top bit and becomes the hidden bit
  assign norm    = i_unp.int_mag << i_unp.lzc;
  assign frac    = norm[fp_pkg::INT_BITS-2 -: fp_pkg::FRAC_BITS];
  assign rnd     = norm[fp_pkg::INT_BITS-2-fp_pkg::FRAC_BITS];
  assign sticky  = |norm[fp_pkg::INT_BITS-3-fp_pkg::FRAC_BITS:0];
  assign inc     = fp_pkg::round_up(i_rm, i_unp.int_sign, frac[0], rnd, sticky);
  assign frac_sum = {1'b0, frac} + {{fp_pkg::FRAC_BITS{1'b0}}, inc};

  always_comb begin
    exp_val = fp_pkg::exp_t'(fp_pkg::EXP_BIAS + fp_pkg::INT_BITS - 1 - int'(i_unp.lzc));
    if (i_unp.int_is_zero) begin
      o_res = '0;
    end else if (frac_sum[fp_pkg::FRAC_BITS]) begin
      // Mantissa overflow after rounding moves up one binade
      o_res.fp = {i_unp.int_sign, exp_val + 1'b1, {fp_pkg::FRAC_BITS{1'b0}}};
      o_res.nx = rnd | sticky;
    end else begin
      o_res.fp = {i_unp.int_sign, exp_val, frac_sum[fp_pkg::FRAC_BITS-1:0]};
      o_res.nx = rnd | sticky;
    end
  end

endmodule

`default_nettype wire

/* fcvt_f2i_round.sv */
// Stages 3 and 4 of float to integer; outputs are valid the cycle after i_advance
`timescale 1ns/1ns
`default_nettype none

module fcvt_f2i_round (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_advance,
  input  cvt_pkg::f2i_pre_t   i_pre,
  input  fp_pkg::round_mode_e i_rm,
  output fp_pkg::int_word_t   o_int,
  output fp_pkg::fp_flags_t   o_flags
);

  logic                        inc;
  logic [fp_pkg::INT_BITS:0]   sum_d;
  logic [fp_pkg::INT_BITS:0]   sum_q;
  cvt_pkg::f2i_pre_t           pre_q;
  logic                        nv;

  // ==================================================
  // Stage 3: rounding increment
  // ==================================================
  assign inc   = fp_pkg::round_up(i_rm, i_pre.sign, i_pre.value[0], i_pre.rnd, i_pre.sticky);
  assign sum_d = {1'b0, i_pre.value} + {{fp_pkg::INT_BITS{1'b0}}, inc};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pre_q <= '0;
      sum_q <= '0;
    end else if (i_advance) begin
      pre_q <= i_pre;
      sum_q <= sum_d;
    end
  end

  // ==================================================
  // Stage 4: sign, saturation and flags
  // ==================================================
  always_comb begin
    nv    = 1'b0;
    o_int = '0;
    if (pre_q.forced) begin
      o_int = pre_q.forced_value;
      nv    = pre_q.forced_nv;
    end else if (pre_q.sign) begin
      if (pre_q.is_unsigned) begin
        // Only a value that rounds to zero is representable
        nv = (sum_q != '0);
      end else if (sum_q > {2'b01, {(fp_pkg::INT_BITS-1){1'b0}}}) begin
        o_int = fp_pkg::INT_MIN;
        nv    = 1'b1;
      end else begin
        o_int = -sum_q[fp_pkg::INT_BITS-1:0];
      end
    end else if (pre_q.is_unsigned) begin
      if (sum_q[fp_pkg::INT_BITS]) begin
        o_int = fp_pkg::UINT_MAX;
        nv    = 1'b1;
      end else begin
        o_int = sum_q[fp_pkg::INT_BITS-1:0];
      end
    end else if (sum_q > {2'b00, {(fp_pkg::INT_BITS-1){1'b1}}}) begin
      o_int = fp_pkg::INT_MAX;
      nv    = 1'b1;
    end else begin
      o_int = sum_q[fp_pkg::INT_BITS-1:0];
    end
    o_flags.nv = nv;
    o_flags.nx = pre_q.inexact_pre & ~nv;
  end

  // Specials decided in stage 2 are always exact
  a_forced_exact : assert property (@(posedge i_clk) disable iff (i_rst)
    pre_q.forced |-> !pre_q.inexact_pre)
    else $error("forced special result carries an inexact flag");

endmodule

`default_nettype wire

/* fp_convert.sv */
// One operation at a time, i_valid is only sampled while idle and o_valid pulses five clocks later
`timescale 1ns/1ns
`default_nettype none

module fp_convert (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_valid,
  input  fp_pkg::fp_word_t    i_fp_operand,
  input  fp_pkg::int_word_t   i_int_operand,
  input  cvt_pkg::cvt_op_e    i_operation,
  input  fp_pkg::round_mode_e i_rounding_mode,
  output fp_pkg::fp_word_t    o_fp_result,
  output fp_pkg::int_word_t   o_int_result,
  output logic                o_is_fp_to_int,
  output fp_pkg::fp_flags_t   o_flags,
  output logic                o_valid
);

  cvt_pkg::cvt_state_e state;
  cvt_pkg::cvt_state_e next_state;

  fp_pkg::fp_word_t    fp_op_q;
  fp_pkg::int_word_t   int_op_q;
  cvt_pkg::cvt_op_e    op_q;
  fp_pkg::round_mode_e rm_q;
  logic                is_signed_op;
  logic                is_unsigned_op;

  cvt_pkg::unpack_t    unp_d;
  cvt_pkg::unpack_t    unp_q;
  cvt_pkg::f2i_pre_t   pre_d;
  cvt_pkg::f2i_pre_t   pre_q;
  cvt_pkg::i2f_res_t   i2f_d;
  cvt_pkg::i2f_res_t   i2f_q;
  fp_pkg::int_word_t   f2i_int;
  fp_pkg::fp_flags_t   f2i_flags;

  fp_pkg::fp_word_t    fp_res_d;
  fp_pkg::int_word_t   int_res_d;
  logic                is_f2i_d;
  fp_pkg::fp_flags_t   flags_d;

  assign is_signed_op   = (op_q == cvt_pkg::OP_FCVT_S_W);
  assign is_unsigned_op = (op_q == cvt_pkg::OP_FCVT_WU_S);

  // ==================================================
  // Sequencer
  // ==================================================
  always_comb begin
    case (state)
      cvt_pkg::ST_IDLE: next_state = i_valid ? cvt_pkg::ST_S1 : cvt_pkg::ST_IDLE;
      cvt_pkg::ST_S1:   next_state = cvt_pkg::ST_S2;
      cvt_pkg::ST_S2:   next_state = cvt_pkg::ST_S3;
      cvt_pkg::ST_S3:   next_state = cvt_pkg::ST_S4;
      default:          next_state = cvt_pkg::ST_IDLE;
    endcase
  end

  // Operands stay put until the operation completes
  always_ff @(posedge i_clk) begin
    if (state == cvt_pkg::ST_IDLE && i_valid) begin
      fp_op_q  <= i_fp_operand;
      int_op_q <= i_int_operand;
      op_q     <= i_operation;
      rm_q     <= i_rounding_mode;
    end
    if (state == cvt_pkg::ST_S1) begin
      unp_q <= unp_d;
    end
    if (state == cvt_pkg::ST_S2) begin
      pre_q <= pre_d;
      i2f_q <= i2f_d;
    end
  end

  // ==================================================
  // Datapath stages
  // ==================================================
  fcvt_unpack u_unpack (
    .i_fp     (fp_op_q),
    .i_int    (int_op_q),
    .i_signed (is_signed_op),
    .o_unp    (unp_d)
  );

  fcvt_f2i_align u_f2i_align (
    .i_unp      (unp_q),
    .i_unsigned (is_unsigned_op),
    .o_pre      (pre_d)
  );

  fcvt_i2f_norm u_i2f_norm (
    .i_unp (unp_q),
    .i_rm  (rm_q),
    .o_res (i2f_d)
  );

  fcvt_f2i_round u_f2i_round (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_advance (state == cvt_pkg::ST_S3),
    .i_pre     (pre_q),
    .i_rm      (rm_q),
    .o_int     (f2i_int),
    .o_flags   (f2i_flags)
  );

  // Result select, unused opcodes leave everything at zero
  always_comb begin
    fp_res_d  = '0;
    int_res_d = '0;
    is_f2i_d  = 1'b0;
    flags_d   = '0;
    case (op_q)
      cvt_pkg::OP_FCVT_W_S, cvt_pkg::OP_FCVT_WU_S: begin
        int_res_d = f2i_int;
        flags_d   = f2i_flags;
        is_f2i_d  = 1'b1;
      end
      cvt_pkg::OP_FCVT_S_W, cvt_pkg::OP_FCVT_S_WU: begin
        fp_res_d   = i2f_q.fp;
        flags_d.nx = i2f_q.nx;
      end
      cvt_pkg::OP_FMV_X_W: begin
        int_res_d = fp_op_q;
        is_f2i_d  = 1'b1;
      end
      cvt_pkg::OP_FMV_W_X: fp_res_d = int_op_q;
      default: ;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state          <= cvt_pkg::ST_IDLE;
      o_valid        <= 1'b0;
      o_fp_result    <= '0;
      o_int_result   <= '0;
      o_is_fp_to_int <= 1'b0;
      o_flags        <= '0;
    end else begin
      state   <= next_state;
      o_valid <= (state == cvt_pkg::ST_S4);
      if (state == cvt_pkg::ST_S4) begin
        o_fp_result    <= fp_res_d;
        o_int_result   <= int_res_d;
        o_is_fp_to_int <= is_f2i_d;
        o_flags        <= flags_d;
      end
    end
  end

  a_valid_single : assert property (@(posedge i_clk) disable iff (i_rst) o_valid |=> !o_valid)
    else $error("o_valid held high for two cycles");

  a_idle_on_done : assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(o_valid) |-> state == cvt_pkg::ST_IDLE)
    else $error("o_valid rose while the sequencer was busy");

endmodule

`default_nettype wire

/* tb_fp_model.svh */
// Bit-exact model of the six conversions using 64-bit integer arithmetic; include inside a module
`ifndef TB_FP_MODEL_SVH
`define TB_FP_MODEL_SVH

// Rounding decision; cmp is -1, 0 or 1 for a remainder below, at or above one half
function automatic bit decide_increment(input logic [2:0] rm, input bit sign, input bit lsb,
                                        input int cmp, input bit inexact);
  case (rm)
    3'd1:    return 1'b0;
    3'd2:    return sign && inexact;
    3'd3:    return !sign && inexact;
    3'd4:    return inexact && (cmp >= 0);
    default: return (cmp > 0) || (cmp == 0 && lsb);
  endcase
endfunction

// Returns {nv, nx, integer}
function automatic logic [33:0] float_to_int_ref(input logic [31:0] f, input bit is_uns,
                                                 input logic [2:0] rm);
  bit                sign;
  bit                nv;
  bit                inexact;
  bit                inc;
  int                e;
  int                sh;
  int                cmp;
  longint unsigned   mant;
  longint unsigned   ip;
  longint unsigned   rem;
  longint unsigned   mag;
  logic [31:0]       val;
  sign = f[31];
  nv   = 1'b0;
  val  = '0;
  cmp  = -1;
  rem  = 0;
  if (f[30:23] == 8'hFF) begin
    // NaN saturates to the positive maximum, infinity follows its sign
    if (f[22:0] != 0 || !sign) begin
      val = is_uns ? 32'hFFFF_FFFF : 32'h7FFF_FFFF;
    end else begin
      val = is_uns ? 32'h0 : 32'h8000_0000;
    end
    return {1'b1, 1'b0, val};
  end
  mant = {40'd0, (f[30:23] != 0), f[22:0]};
  e    = ((f[30:23] == 0) ? 1 : int'(f[30:23])) - 150;
  if (e >= 40) begin
    ip = 64'h4000_0000_0000_0000;
  end else if (e >= 0) begin
    ip = mant << e;
  end else begin
    sh = -e;
    if (sh > 60) begin
      ip  = 0;
      rem = mant;
    end else begin
      ip  = mant >> sh;
      rem = mant & ((64'd1 << sh) - 1);
      cmp = (rem > (64'd1 << (sh - 1))) ? 1 : ((rem == (64'd1 << (sh - 1))) ? 0 : -1);
    end
  end
  inexact = (rem != 0);
  inc     = decide_increment(rm, sign, ip[0], cmp, inexact);
  mag     = ip + 64'(inc);
  if (!is_uns) begin
    if (!sign && mag > 64'h7FFF_FFFF) begin
      nv  = 1'b1;
      val = 32'h7FFF_FFFF;
    end else if (sign && mag > 64'h8000_0000) begin
      nv  = 1'b1;
      val = 32'h8000_0000;
    end else begin
      val = sign ? 32'(-mag) : 32'(mag);
    end
  end else if (sign) begin
    // Anything below zero after rounding is out of range
    nv = (mag != 0);
  end else if (mag > 64'hFFFF_FFFF) begin
    nv  = 1'b1;
    val = 32'hFFFF_FFFF;
  end else begin
    val = 32'(mag);
  end
  return {nv, inexact && !nv, val};
endfunction

// Returns {nx, float bits}
function automatic logic [32:0] int_to_float_ref(input logic [31:0] i, input bit is_sgn,
                                                 input logic [2:0] rm);
  bit                sign;
  bit                inexact;
  bit                inc;
  int                p;
  int                sh;
  int                cmp;
  logic [31:0]       neg;
  longint unsigned   mag;
  longint unsigned   kept;
  longint unsigned   rem;
  sign    = is_sgn && i[31];
  neg     = -i;
  mag     = sign ? 64'(neg) : 64'(i);
  inexact = 1'b0;
  cmp     = -1;
  p       = 0;
  if (mag == 0) begin
    return '0;
  end
  for (int b = 0; b < 32; b++) begin
    if (mag[b]) begin
      p = b;
    end
  end
  if (p <= 23) begin
    kept = mag << (23 - p);
  end else begin
    sh      = p - 23;
    kept    = mag >> sh;
    rem     = mag & ((64'd1 << sh) - 1);
    cmp     = (rem > (64'd1 << (sh - 1))) ? 1 : ((rem == (64'd1 << (sh - 1))) ? 0 : -1);
    inexact = (rem != 0);
  end
  inc  = decide_increment(rm, sign, kept[0], cmp, inexact);
  kept = kept + 64'(inc);
  // Carry out of the mantissa bumps the exponent
  if (kept[24]) begin
    kept = kept >> 1;
    p    = p + 1;
  end
  return {inexact, sign, 8'(127 + p), kept[22:0]};
endfunction

`endif

/* tb_fp_convert.sv */
// Random and directed checks of fp_convert against a behavioral model; one operation in flight
`timescale 1ns/1ns
`default_nettype none

module tb_fp_convert;

  localparam int N_PROTOCOL = 4;
  localparam int N_MOVE     = 200;
  localparam int N_I2F      = 300;
  localparam int N_F2I      = 300;
  localparam int N_SPECIAL  = 160;
  localparam int TOTAL_OPS  = N_PROTOCOL + N_MOVE + N_I2F + N_F2I + N_SPECIAL;
  localparam int MAX_WAIT   = 20;

  // NaNs, infinities, zeros, subnormals and the edges of the 32-bit ranges
  localparam logic [31:0] SPECIALS [16] = '{
    32'h7FC0_0000, 32'h7F80_0001, 32'h7F80_0000, 32'hFF80_0000,
    32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 32'h807F_FFFF,
    32'h4F00_0000, 32'hCF00_0000, 32'h4F00_0001, 32'h4EFF_FFFF,
    32'hBECC_CCCD, 32'hBF19_999A, 32'h4F80_0000, 32'h4F7F_FFFF
  };

  logic                i_clk;
  logic                i_rst;
  logic                i_valid;
  fp_pkg::fp_word_t    i_fp_operand;
  fp_pkg::int_word_t   i_int_operand;
  cvt_pkg::cvt_op_e    i_operation;
  fp_pkg::round_mode_e i_rounding_mode;
  fp_pkg::fp_word_t    o_fp_result;
  fp_pkg::int_word_t   o_int_result;
  logic                o_is_fp_to_int;
  fp_pkg::fp_flags_t   o_flags;
  logic                o_valid;

  integer seed = 32'h2121;
  int     checks = 0;
  int     errors = 0;
  int     tests = 0;

  `include "tb_fp_model.svh"

  fp_convert u_fp_convert (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_fp_operand    (i_fp_operand),
    .i_int_operand   (i_int_operand),
    .i_operation     (i_operation),
    .i_rounding_mode (i_rounding_mode),
    .o_fp_result     (o_fp_result),
    .o_int_result    (o_int_result),
    .o_is_fp_to_int  (o_is_fp_to_int),
    .o_flags         (o_flags),
    .o_valid         (o_valid)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Watchdog sized at twice eight cycles per operation
  initial begin
    #(TOTAL_OPS * 8 * 10 * 2);
    $display("Watchdog expired before all tests finished");
    $display("Something failed");
    $finish;
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error %s: got %h, expected %h", name, got, want);
    end
  endtask

  task automatic report_test(input string name, input int checks_before, input int errors_before);
    tests++;
    $display("%s: %0d checks, %0d errors", name, checks - checks_before, errors - errors_before);
  endtask

  // Five codes plus one code above RMM
  function automatic logic [2:0] pick_mode();
    int unsigned code;
    code = $unsigned($random(seed)) % 6;
    return (code == 5) ? 3'd7 : code[2:0];
  endfunction

  // Called on a falling edge, returns on the falling edge where o_valid is seen
  task automatic issue_op(input logic [2:0] op, input logic [31:0] fp, input logic [31:0] iv,
                          input logic [2:0] rm);
    int waited;
    i_operation     = cvt_pkg::cvt_op_e'(op);
    i_fp_operand    = fp;
    i_int_operand   = iv;
    i_rounding_mode = fp_pkg::round_mode_e'(rm);
    i_valid         = 1'b1;
    @(negedge i_clk);
    i_valid = 1'b0;
    waited  = 1;
    while (!o_valid && waited < MAX_WAIT) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_valid) begin
      errors++;
      $display("No o_valid within %0d cycles of an accepted operation", MAX_WAIT);
    end
  endtask

  task automatic check_f2i(input logic [31:0] fp, input bit is_uns, input logic [2:0] rm);
    logic [33:0] want;
    want = float_to_int_ref(fp, is_uns, rm);
    issue_op(is_uns ? cvt_pkg::OP_FCVT_WU_S : cvt_pkg::OP_FCVT_W_S, fp, '0, rm);
    check_value("o_int_result", o_int_result, want[31:0]);
    check_value("o_flags.nv", 32'(o_flags.nv), 32'(want[33]));
    check_value("o_flags.nx", 32'(o_flags.nx), 32'(want[32]));
    check_value("o_is_fp_to_int", 32'(o_is_fp_to_int), 32'd1);
  endtask

  // ==================================================
  // Tests
  // ==================================================
  task automatic protocol_test();
    int c0;
    int e0;
    int pulses;
    int first_seen;
    c0         = checks;
    e0         = errors;
    pulses     = 0;
    first_seen = 0;
    check_value("o_valid", 32'(o_valid), 32'd0);
    i_operation  = cvt_pkg::OP_FMV_X_W;
    i_fp_operand = $random(seed);
    i_valid      = 1'b1;
    for (int c = 1; c <= 15; c++) begin
      @(negedge i_clk);
      if (o_valid) begin
        pulses++;
        if (first_seen == 0) begin
          first_seen = c;
        end
      end
      // Strobes while busy must be ignored
      i_valid = (c == 2 || c == 3);
    end
    check_value("o_valid pulse count", 32'(pulses), 32'd1);
    check_value("o_valid latency", 32'(first_seen), 32'd5);
    // Unused opcode completes with zero results
    issue_op(3'd6, $random(seed), $random(seed), 3'd0);
    check_value("o_int_result", o_int_result, '0);
    check_value("o_fp_result", o_fp_result, '0);
    check_value("o_flags.nv", 32'(o_flags.nv), 32'd0);
    check_value("o_flags.nx", 32'(o_flags.nx), 32'd0);
    report_test("protocol", c0, e0);
  endtask

  task automatic move_test();
    int          c0;
    int          e0;
    logic [31:0] word;
    c0 = checks;
    e0 = errors;
    for (int n = 0; n < N_MOVE; n++) begin
      word = $random(seed);
      if ($random(seed) & 1) begin
        issue_op(cvt_pkg::OP_FMV_X_W, word, '0, pick_mode());
        check_value("o_int_result", o_int_result, word);
        check_value("o_is_fp_to_int", 32'(o_is_fp_to_int), 32'd1);
      end else begin
        issue_op(cvt_pkg::OP_FMV_W_X, '0, word, pick_mode());
        check_value("o_fp_result", o_fp_result, word);
        check_value("o_is_fp_to_int", 32'(o_is_fp_to_int), 32'd0);
      end
      check_value("o_flags.nv", 32'(o_flags.nv), 32'd0);
      check_value("o_flags.nx", 32'(o_flags.nx), 32'd0);
    end
    report_test("moves", c0, e0);
  endtask

  task automatic i2f_test();
    int          c0;
    int          e0;
    int unsigned kind;
    bit          is_sgn;
    logic [2:0]  rm;
    logic [31:0] value;
    logic [32:0] want;
    c0 = checks;
    e0 = errors;
    for (int n = 0; n < N_I2F; n++) begin
      value  = $random(seed);
      kind   = $unsigned($random(seed)) % 3;
      is_sgn = $random(seed) & 1;
      rm     = pick_mode();
      if (kind == 0) begin
        value = $signed(value) >>> 20;
      end else if (kind == 1) begin
        value = value & 32'h00FF_FFFF;
      end
      want = int_to_float_ref(value, is_sgn, rm);
      issue_op(is_sgn ? cvt_pkg::OP_FCVT_S_W : cvt_pkg::OP_FCVT_S_WU, '0, value, rm);
      check_value("o_fp_result", o_fp_result, want[31:0]);
      check_value("o_flags.nx", 32'(o_flags.nx), 32'(want[32]));
      check_value("o_flags.nv", 32'(o_flags.nv), 32'd0);
      check_value("o_is_fp_to_int", 32'(o_is_fp_to_int), 32'd0);
    end
    report_test("int to float", c0, e0);
  endtask

  task automatic f2i_test();
    int          c0;
    int          e0;
    int unsigned exp_val;
    logic [31:0] bits;
    c0 = checks;
    e0 = errors;
    for (int n = 0; n < N_F2I; n++) begin
      bits    = $random(seed);
      exp_val = 100 + ($unsigned($random(seed)) % 61);
      bits    = {bits[31], exp_val[7:0], bits[22:0]};
      check_f2i(bits, $random(seed) & 1, pick_mode());
    end
    report_test("float to int", c0, e0);
  endtask

  task automatic special_test();
    int c0;
    int e0;
    c0 = checks;
    e0 = errors;
    foreach (SPECIALS[k]) begin
      for (int u = 0; u < 2; u++) begin
        for (int rm = 0; rm < 5; rm++) begin
          check_f2i(SPECIALS[k], u[0], rm[2:0]);
        end
      end
    end
    report_test("special values", c0, e0);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    i_rst           = 1'b1;
    i_valid         = 1'b0;
    i_fp_operand    = '0;
    i_int_operand   = '0;
    i_operation     = cvt_pkg::OP_FCVT_W_S;
    i_rounding_mode = fp_pkg::RM_RNE;
    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;
    protocol_test();
    move_test();
    i2f_test();
    f2i_test();
    special_test();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
fp_pkg.sv
cvt_pkg.sv
fcvt_unpack.sv
fcvt_f2i_align.sv
fcvt_i2f_norm.sv
fcvt_f2i_round.sv
fp_convert.sv
tb_fp_convert.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_fp_convert \
  -o sim_fp_convert && ./obj_dir/sim_fp_convert | tee /dev/stderr | grep -q "Everything OK" \
  && echo "simulation passed" || { echo "simulation failed"; exit 1; }
